// ==== isp.f ====
rtl/isp_pkg.sv
rtl/white_balance.sv
rtl/color_matrix.sv
rtl/pixel_path.sv
rtl/write_address_gen.sv
rtl/write_packer.sv
rtl/isp_top.sv
tb/isp_assert.sv
tb/isp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ISP testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module isp_tb -f isp.f -o Visp_tb

./obj_dir/Visp_tb +verilator+error+limit+100000 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
else
    echo "simulation did not report success, see sim.log"
    exit 1
fi

// ==== tb/isp_tb.sv ====
module isp_tb import isp_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int PHASE_CYCLES = 300;
    localparam int DRAIN_MARGIN = 1000;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 3 * PHASE_CYCLES + DRAIN_MARGIN;
    localparam int PIPE_DEPTH   = 3;

    // unity values for the default fraction widths
    localparam gain_t  GAIN_ONE = 16'd256;
    localparam coeff_t CC_ONE   = 28'sd64;
    localparam coeff_t CC_ZERO  = 28'sd0;

    logic   clk;
    logic   reset;
    logic   pixel_valid;
    pixel_t red_in;
    pixel_t green_in;
    pixel_t blue_in;
    logic   new_frame;
    pixel_t black_level;
    gain_t  gain_red;
    gain_t  gain_green;
    gain_t  gain_blue;
    coeff_t cc_coeff [9];
    addr_t  init_write_address;
    logic   write_enable;
    addr_t  write_address;
    word_t  write_data;

    logic [15:0] lfsr_state  = 16'd47310;
    int          cycle_count = 0;

    isp_top uut (
        .clk                (clk),
        .reset              (reset),
        .pixel_valid        (pixel_valid),
        .red_in             (red_in),
        .green_in           (green_in),
        .blue_in            (blue_in),
        .new_frame          (new_frame),
        .black_level        (black_level),
        .gain_red           (gain_red),
        .gain_green         (gain_green),
        .gain_blue          (gain_blue),
        .cc_coeff           (cc_coeff),
        .init_write_address (init_write_address),
        .write_enable       (write_enable),
        .write_address      (write_address),
        .write_data         (write_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    task automatic set_balance(input pixel_t black, input gain_t red_gain,
                               input gain_t green_gain, input gain_t blue_gain);
        black_level = black;
        gain_red    = red_gain;
        gain_green  = green_gain;
        gain_blue   = blue_gain;
    endtask

    task automatic set_matrix(input coeff_t c0, input coeff_t c1, input coeff_t c2,
                              input coeff_t c3, input coeff_t c4, input coeff_t c5,
                              input coeff_t c6, input coeff_t c7, input coeff_t c8);
        cc_coeff = '{c0, c1, c2, c3, c4, c5, c6, c7, c8};
    endtask

    // first pixel carries new_frame, then about 70% valid cycles
    task automatic stream_frame(input addr_t base, input int cycles);
        logic [31:0] pick;
        init_write_address = base;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            pick        = random_bits(4);
            new_frame   = (i == 0);
            pixel_valid = (i == 0) || (pick < 11);
            red_in      = pixel_t'(random_bits(PIXEL_WIDTH));
            green_in    = pixel_t'(random_bits(PIXEL_WIDTH));
            blue_in     = pixel_t'(random_bits(PIXEL_WIDTH));
        end
        @(negedge clk);
        pixel_valid = 1'b0;
        new_frame   = 1'b0;
    endtask

    task automatic drain_pipeline();
        repeat (PIPE_DEPTH + 1) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int errors;
        reset              = 1'b1;
        pixel_valid        = 1'b0;
        new_frame          = 1'b0;
        red_in             = '0;
        green_in           = '0;
        blue_in            = '0;
        init_write_address = '0;
        set_balance('0, GAIN_ONE, GAIN_ONE, GAIN_ONE);
        set_matrix(CC_ONE, CC_ZERO, CC_ZERO, CC_ZERO, CC_ONE, CC_ZERO,
                   CC_ZERO, CC_ZERO, CC_ONE);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // identity settings, output equals input
        stream_frame(32'h0000_1000, PHASE_CYCLES);
        drain_pipeline();

        // black clamp, red and green saturate, blue stays in range
        set_balance(16'h3000, 16'h0400, 16'h0180, 16'h00C0);
        stream_frame(32'h0002_0000, PHASE_CYCLES);
        drain_pipeline();

        // mixed sign rows and one huge coefficient, base wraps past zero
        set_balance('0, GAIN_ONE, GAIN_ONE, GAIN_ONE);
        set_matrix(28'sd96, -28'sd40, -28'sd24, -28'sd128, CC_ONE, 28'sd32,
                   CC_ZERO, CC_ZERO, 28'sd134217727);
        stream_frame(32'hFFFF_FF80, PHASE_CYCLES);
        drain_pipeline();

        errors = uut.checks.error_count;
        $display("run complete after %0d cycles with %0d errors", cycle_count, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb/isp_assert.sv ====
module isp_assert import isp_pkg::*; #(
    parameter int WB_FRAC_BITS = 8,
    parameter int CC_FRAC_BITS = 6
) (
    input logic   clk,
    input logic   reset,
    input logic   pixel_valid,
    input pixel_t red_in,
    input pixel_t green_in,
    input pixel_t blue_in,
    input logic   new_frame,
    input pixel_t black_level,
    input gain_t  gain_red,
    input gain_t  gain_green,
    input gain_t  gain_blue,
    input coeff_t cc_coeff [9],
    input addr_t  init_write_address,
    input logic   write_enable,
    input addr_t  write_address,
    input word_t  write_data
);

    localparam longint SAMPLE_MAX = longint'(PIXEL_MAX);
    localparam int     PAD_BITS   = WORD_WIDTH - 3 * PIXEL_WIDTH;

    int error_count = 0;

    pixel_t       wb_red;
    pixel_t       wb_green;
    pixel_t       wb_blue;
    word_t        expected_word;
    addr_t        expected_address;
    addr_t        address_count;
    logic [2:0]   valid_pipe;
    word_t [2:0]  word_pipe;
    addr_t [2:0]  addr_pipe;

    // subtract black, clamp at zero, scale by gain, saturate
    function automatic pixel_t balance_ref(pixel_t pix, pixel_t black, gain_t gain);
        longint level;
        longint scaled;
        level = longint'(pix) - longint'(black);
        if (level < 0) begin
            level = 0;
        end
        scaled = (level * longint'(gain)) >>> WB_FRAC_BITS;
        if (scaled > SAMPLE_MAX) begin
            scaled = SAMPLE_MAX;
        end
        return pixel_t'(scaled);
    endfunction

    // one matrix row, negative to zero, integer part saturated
    function automatic pixel_t matrix_ref(pixel_t r, pixel_t g, pixel_t b,
                                          coeff_t k0, coeff_t k1, coeff_t k2);
        longint sum;
        longint whole;
        sum = longint'(r) * longint'(k0) + longint'(g) * longint'(k1)
            + longint'(b) * longint'(k2);
        if (sum < 0) begin
            return '0;
        end
        whole = sum >>> CC_FRAC_BITS;
        if (whole > SAMPLE_MAX) begin
            return PIXEL_MAX;
        end
        return pixel_t'(whole);
    endfunction

    always_comb begin
        wb_red        = balance_ref(red_in, black_level, gain_red);
        wb_green      = balance_ref(green_in, black_level, gain_green);
        wb_blue       = balance_ref(blue_in, black_level, gain_blue);
        expected_word = {
            matrix_ref(wb_red, wb_green, wb_blue, cc_coeff[0], cc_coeff[1], cc_coeff[2]),
            matrix_ref(wb_red, wb_green, wb_blue, cc_coeff[3], cc_coeff[4], cc_coeff[5]),
            matrix_ref(wb_red, wb_green, wb_blue, cc_coeff[6], cc_coeff[7], cc_coeff[8]),
            {PAD_BITS{1'b0}}
        };
    end

    // frame start gives the base, else the running count
    assign expected_address = new_frame ? init_write_address : address_count;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            address_count <= '0;
            valid_pipe    <= '0;
            word_pipe     <= '0;
            addr_pipe     <= '0;
        end else begin
            if (pixel_valid) begin
                address_count <= expected_address + addr_t'(1);
            end
            valid_pipe <= {valid_pipe[1:0], pixel_valid};
            word_pipe  <= {word_pipe[1:0], expected_word};
            addr_pipe  <= {addr_pipe[1:0], expected_address};
        end
    end

    reset_idle: assert property (@(posedge clk) reset |-> !write_enable)
        else begin
            error_count++;
            $error("ERR t=%0t write_enable got %b expected 0 while reset is held", $time,
                   $sampled(write_enable));
        end

    write_strobe: assert property (@(posedge clk) disable iff (reset)
        write_enable == valid_pipe[2])
        else begin
            error_count++;
            $error("ERR t=%0t write_enable got %b expected %b", $time,
                   $sampled(write_enable), $sampled(valid_pipe[2]));
        end

    write_word: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> write_data == word_pipe[2])
        else begin
            error_count++;
            $error("ERR t=%0t write_data got %h expected %h", $time,
                   $sampled(write_data), $sampled(word_pipe[2]));
        end

    write_addr: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> write_address == addr_pipe[2])
        else begin
            error_count++;
            $error("ERR t=%0t write_address got %h expected %h", $time,
                   $sampled(write_address), $sampled(addr_pipe[2]));
        end

endmodule

bind isp_top isp_assert #(
    .WB_FRAC_BITS (WB_FRAC_BITS),
    .CC_FRAC_BITS (CC_FRAC_BITS)
) checks (.*);

// ==== rtl/isp_top.sv ====
module isp_top import isp_pkg::*; #(
    parameter int WB_FRAC_BITS = 8,
    parameter int CC_FRAC_BITS = 6
) (
    input  logic   clk,
    input  logic   reset,
    // pixel stream
    input  logic   pixel_valid,
    input  pixel_t red_in,
    input  pixel_t green_in,
    input  pixel_t blue_in,
    input  logic   new_frame,
    // static configuration
    input  pixel_t black_level,
    input  gain_t  gain_red,
    input  gain_t  gain_green,
    input  gain_t  gain_blue,
    input  coeff_t cc_coeff [9],
    input  addr_t  init_write_address,
    // memory write port
    output logic   write_enable,
    output addr_t  write_address,
    output word_t  write_data
);

    logic   proc_valid;
    pixel_t proc_red;
    pixel_t proc_green;
    pixel_t proc_blue;
    addr_t  pixel_address;

    pixel_path #(
        .WB_FRAC_BITS (WB_FRAC_BITS),
        .CC_FRAC_BITS (CC_FRAC_BITS)
    ) path (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .red_in      (red_in),
        .green_in    (green_in),
        .blue_in     (blue_in),
        .black_level (black_level),
        .gain_red    (gain_red),
        .gain_green  (gain_green),
        .gain_blue   (gain_blue),
        .cc_coeff    (cc_coeff),
        .proc_valid  (proc_valid),
        .proc_red    (proc_red),
        .proc_green  (proc_green),
        .proc_blue   (proc_blue)
    );

    write_address_gen addr_gen (
        .clk                (clk),
        .reset              (reset),
        .pixel_valid        (pixel_valid),
        .new_frame          (new_frame),
        .init_write_address (init_write_address),
        .pixel_address      (pixel_address)
    );

    write_packer packer (
        .clk           (clk),
        .reset         (reset),
        .proc_valid    (proc_valid),
        .proc_red      (proc_red),
        .proc_green    (proc_green),
        .proc_blue     (proc_blue),
        .pixel_address (pixel_address),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data)
    );

endmodule

// ==== rtl/write_packer.sv ====
module write_packer import isp_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   proc_valid,
    input  pixel_t proc_red,
    input  pixel_t proc_green,
    input  pixel_t proc_blue,
    input  addr_t  pixel_address,
    output logic   write_enable,
    output addr_t  write_address,
    output word_t  write_data
);

    localparam int PAD_WIDTH = WORD_WIDTH - 3 * PIXEL_WIDTH;

    word_t packed_word;

    // red at the top, zero padding at the bottom
    assign packed_word = {proc_red, proc_green, proc_blue, {PAD_WIDTH{1'b0}}};

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= proc_valid;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            write_address <= '0;
            write_data    <= '0;
        end else if (proc_valid) begin
            write_address <= pixel_address;
            write_data    <= packed_word;
        end
    end

endmodule

// ==== rtl/write_address_gen.sv ====
module write_address_gen import isp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  pixel_valid,
    input  logic  new_frame,
    input  addr_t init_write_address,
    output addr_t pixel_address
);

    addr_t next_address;
    addr_t current_address;
    addr_t address_d1;

    // frame start overrides the running count
    assign current_address = new_frame ? init_write_address : next_address;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            next_address <= '0;
        end else begin
            next_address <= current_address + addr_t'(pixel_valid);
        end
    end

    // two stages to line up with white balance and colour matrix
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            address_d1    <= '0;
            pixel_address <= '0;
        end else begin
            address_d1    <= current_address;
            pixel_address <= address_d1;
        end
    end

endmodule

// ==== rtl/pixel_path.sv ====
module pixel_path import isp_pkg::*; #(
    parameter int WB_FRAC_BITS = 8,
    parameter int CC_FRAC_BITS = 6
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   pixel_valid,
    input  pixel_t red_in,
    input  pixel_t green_in,
    input  pixel_t blue_in,
    input  pixel_t black_level,
    input  gain_t  gain_red,
    input  gain_t  gain_green,
    input  gain_t  gain_blue,
    input  coeff_t cc_coeff [9],
    output logic   proc_valid,
    output pixel_t proc_red,
    output pixel_t proc_green,
    output pixel_t proc_blue
);

    logic   wb_valid;
    pixel_t wb_red;
    pixel_t wb_green;
    pixel_t wb_blue;

    // valid strobe follows the data, one flop per stage
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wb_valid   <= 1'b0;
            proc_valid <= 1'b0;
        end else begin
            wb_valid   <= pixel_valid;
            proc_valid <= wb_valid;
        end
    end

    white_balance #(
        .WB_FRAC_BITS (WB_FRAC_BITS)
    ) wb (
        .clk         (clk),
        .reset       (reset),
        .enable      (pixel_valid),
        .red_in      (red_in),
        .green_in    (green_in),
        .blue_in     (blue_in),
        .black_level (black_level),
        .gain_red    (gain_red),
        .gain_green  (gain_green),
        .gain_blue   (gain_blue),
        .red_out     (wb_red),
        .green_out   (wb_green),
        .blue_out    (wb_blue)
    );

    color_matrix #(
        .CC_FRAC_BITS (CC_FRAC_BITS)
    ) cc (
        .clk       (clk),
        .reset     (reset),
        .enable    (wb_valid),
        .red_in    (wb_red),
        .green_in  (wb_green),
        .blue_in   (wb_blue),
        .cc_coeff  (cc_coeff),
        .red_out   (proc_red),
        .green_out (proc_green),
        .blue_out  (proc_blue)
    );

endmodule

// ==== rtl/color_matrix.sv ====
module color_matrix import isp_pkg::*; #(
    parameter int CC_FRAC_BITS = 6
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  pixel_t red_in,
    input  pixel_t green_in,
    input  pixel_t blue_in,
    input  coeff_t cc_coeff [9],
    output pixel_t red_out,
    output pixel_t green_out,
    output pixel_t blue_out
);

    // product of 17-bit signed sample and coefficient, plus growth for three terms
    localparam int SUM_WIDTH = PIXEL_WIDTH + COEFF_WIDTH + 3;
    localparam int INT_LSB   = CC_FRAC_BITS;
    localparam int OVF_LSB   = CC_FRAC_BITS + PIXEL_WIDTH;

    pixel_t red_calc;
    pixel_t green_calc;
    pixel_t blue_calc;

    // one matrix row, clamped to the sample range
    function automatic pixel_t mac_row(
        pixel_t r,
        pixel_t g,
        pixel_t b,
        coeff_t c0,
        coeff_t c1,
        coeff_t c2
    );
        logic signed [PIXEL_WIDTH:0]  r_s;
        logic signed [PIXEL_WIDTH:0]  g_s;
        logic signed [PIXEL_WIDTH:0]  b_s;
        logic signed [SUM_WIDTH-1:0]  sum;
        r_s = $signed({1'b0, r});
        g_s = $signed({1'b0, g});
        b_s = $signed({1'b0, b});
        sum = r_s * c0 + g_s * c1 + b_s * c2;
        if (sum[SUM_WIDTH-1]) begin
            return '0;
        end
        // integer part above the sample range
        if (|sum[SUM_WIDTH-2:OVF_LSB]) begin
            return PIXEL_MAX;
        end
        return sum[INT_LSB +: PIXEL_WIDTH];
    endfunction

    always_comb begin
        red_calc   = mac_row(red_in, green_in, blue_in,
                             cc_coeff[0], cc_coeff[1], cc_coeff[2]);
        green_calc = mac_row(red_in, green_in, blue_in,
                             cc_coeff[3], cc_coeff[4], cc_coeff[5]);
        blue_calc  = mac_row(red_in, green_in, blue_in,
                             cc_coeff[6], cc_coeff[7], cc_coeff[8]);
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            red_out   <= '0;
            green_out <= '0;
            blue_out  <= '0;
        end else if (enable) begin
            red_out   <= red_calc;
            green_out <= green_calc;
            blue_out  <= blue_calc;
        end
    end

endmodule

// ==== rtl/white_balance.sv ====
module white_balance import isp_pkg::*; #(
    parameter int WB_FRAC_BITS = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  pixel_t red_in,
    input  pixel_t green_in,
    input  pixel_t blue_in,
    input  pixel_t black_level,
    input  gain_t  gain_red,
    input  gain_t  gain_green,
    input  gain_t  gain_blue,
    output pixel_t red_out,
    output pixel_t green_out,
    output pixel_t blue_out
);

    localparam int PROD_WIDTH = PIXEL_WIDTH + GAIN_WIDTH;

    pixel_t red_calc;
    pixel_t green_calc;
    pixel_t blue_calc;

    // black level removal, gain, saturation
    function automatic pixel_t balance(pixel_t pix, pixel_t black, gain_t gain);
        pixel_t                  diff;
        logic [PROD_WIDTH-1:0]   prod;
        logic [PROD_WIDTH-1:0]   scaled;
        diff   = (pix > black) ? pix - black : '0;
        prod   = diff * gain;
        scaled = prod >> WB_FRAC_BITS;
        if (scaled > PROD_WIDTH'(PIXEL_MAX)) begin
            return PIXEL_MAX;
        end
        return scaled[PIXEL_WIDTH-1:0];
    endfunction

    always_comb begin
        red_calc   = balance(red_in, black_level, gain_red);
        green_calc = balance(green_in, black_level, gain_green);
        blue_calc  = balance(blue_in, black_level, gain_blue);
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            red_out   <= '0;
            green_out <= '0;
            blue_out  <= '0;
        end else if (enable) begin
            red_out   <= red_calc;
            green_out <= green_calc;
            blue_out  <= blue_calc;
        end
    end

endmodule

// ==== rtl/isp_pkg.sv ====
package isp_pkg;

    // sample and configuration widths
    localparam int PIXEL_WIDTH = 16;
    localparam int GAIN_WIDTH  = 16;
    localparam int COEFF_WIDTH = 28;
    localparam int ADDR_WIDTH  = 32;
    localparam int WORD_WIDTH  = 64;

    // one colour sample
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // unsigned white balance gain, fraction set per instance
    typedef logic [GAIN_WIDTH-1:0] gain_t;

    // signed colour matrix coefficient
    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;

    // memory word address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // memory write word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // saturation value of a sample
    localparam pixel_t PIXEL_MAX = '1;

endpackage
